/* pri_icache.f */
+incdir+.
icache_addr_pkg.sv
icache_ctrl_pkg.sv
icache_cfg_regs.sv
icache_tag_bank.sv
icache_data_bank.sv
icache_controller.sv
pri_icache.sv
tb_pri_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -f pri_icache.f --top-module tb_pri_icache -o tb_pri_icache &&
./obj_dir/tb_pri_icache ||
{ echo "Simulation did not complete cleanly"; exit 1; }

/* tb_pri_icache.sv */
// Self-checking testbench for the private instruction cache
// Applies a table of fetches with bypass and flush controls, predicts refills
// with a reference cache model and serves refills from a delayed memory model

`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module tb_pri_icache;

   typedef struct packed {
      logic [`ICACHE_ADDR_W-1:0] addr;
      logic                      bypass;
      logic                      flush;
   } row_t;

   localparam int NB_ROWS     = 20;
   localparam int TIMEOUT_CYC = NB_ROWS * 40 + 8;   // Reset and settle slack

   logic                        clk = 1'b0;
   logic                        arst_n_i;
   logic                        fetch_req_i;
   logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i;
   logic                        fetch_gnt_o;
   logic                        fetch_rvalid_o;
   logic [`ICACHE_FETCH_W-1:0]  fetch_rdata_o;
   logic                        refill_req_o;
   logic                        refill_gnt_i;
   logic [`ICACHE_ADDR_W-1:0]   refill_addr_o;
   logic                        refill_r_valid_i;
   logic [`ICACHE_LINE_W-1:0]   refill_r_data_i;
   logic                        bypass_icache_i;
   logic                        cache_is_bypassed_o;
   logic                        flush_icache_i;
   logic                        cache_is_flushed_o;

   row_t                        rows [NB_ROWS];
   logic [`ICACHE_ADDR_W-1:0]   cur_addr;            // Address of the fetch in flight
   integer                      seed = 18254;
   int                          cycle = 0;
   int                          gnt_total = 0;       // Monotonic, only the monitor writes
   int                          rv_total = 0;
   int                          ref_total = 0;
   int                          gnt_cyc;
   int                          rv_cyc;
   logic [`ICACHE_FETCH_W-1:0]  rv_data;

   // Reference model state
   icache_addr_pkg::tag_t       m_tag   [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];
   logic [`ICACHE_NB_WAYS-1:0]  m_valid [`ICACHE_NB_SETS];
   logic                        m_rr    [`ICACHE_NB_SETS];

   always #2 clk = ~clk;   // 4 ns period

   pri_icache u_dut
   (
      .clk                 ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_icache_i      ( flush_icache_i      ),
      .cache_is_flushed_o  ( cache_is_flushed_o  )
   );

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic stop_run(input string line);
      $display("%s", line);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check(input bit cond, input string msg);
      assert (cond)
      else
         stop_run($sformatf("FAILED at %0t ns: %s", $time, msg));
   endtask

   // Memory content, every word is its byte address XOR a fixed mask
   function automatic logic [`ICACHE_LINE_W-1:0] line_of(input logic [31:0] line_addr);
      logic [`ICACHE_LINE_W-1:0] line;
      for (int i = 0; i < 4; i++)
         line[32*i +: 32] = (line_addr + 32'(4 * i)) ^ 32'hA5A5_0000;
      return line;
   endfunction

   task automatic model_invalidate();
      for (int s = 0; s < `ICACHE_NB_SETS; s++)
         m_valid[s] = '0;   // Round-robin bits survive
   endtask

   // Predicts a refill and updates the model like the cache would
   task automatic model_access(input logic [31:0] addr, input logic byp, output int refill);
      icache_addr_pkg::fetch_addr_t fa;
      int                           way;
      fa     = icache_addr_pkg::fetch_addr_t'(addr);
      refill = 1;
      if (!byp)
      begin
         for (int w = 0; w < `ICACHE_NB_WAYS; w++)
            if (m_valid[fa.set][w] && m_tag[w][fa.set] == fa.tag)
               refill = 0;
         if (refill == 1)
         begin
            if (!m_valid[fa.set][0])
               way = 0;
            else if (!m_valid[fa.set][1])
               way = 1;
            else
               way = m_rr[fa.set] ? 1 : 0;
            m_tag[way][fa.set]   = fa.tag;
            m_valid[fa.set][way] = 1'b1;
            m_rr[fa.set]         = ~m_rr[fa.set];   // Toggles on every line write
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Monitor and memory model
   //////////////////////////////////////////////////////////////////////

   // Outputs sampled at the rising edge, before any flop updates
   always @(posedge clk)
   begin
      cycle++;
      if (fetch_gnt_o)
      begin
         gnt_total++;
         gnt_cyc = cycle;
      end
      if (fetch_rvalid_o)
      begin
         rv_total++;
         rv_cyc  = cycle;
         rv_data = fetch_rdata_o;
      end
      if (refill_req_o && refill_gnt_i)
         ref_total++;
      if (cycle > TIMEOUT_CYC)
         stop_run("Timeout: the fetch sequence did not finish within the cycle limit");
   end

   initial
   begin : memory_model
      int unsigned               gnt_dly;
      int unsigned               beat_dly;
      logic [`ICACHE_ADDR_W-1:0] req_addr;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      forever
      begin
         @(negedge clk);
         if (refill_req_o)
         begin
            req_addr = refill_addr_o;
            check(req_addr[3:0] == 4'h0, "refill address not line aligned");
            check(req_addr == {cur_addr[31:4], 4'h0}, "refill address does not match fetch");
            gnt_dly = $unsigned($random(seed)) % 4;
            repeat (gnt_dly)
            begin
               @(negedge clk);
               check(refill_req_o && refill_addr_o == req_addr,
                     "refill request or address changed before grant");
            end
            refill_gnt_i = 1'b1;
            @(negedge clk);
            refill_gnt_i = 1'b0;
            beat_dly     = 1 + $unsigned($random(seed)) % 3;
            repeat (beat_dly - 1) @(negedge clk);
            refill_r_valid_i = 1'b1;   // Beat lands 1 to 3 cycles after the grant
            refill_r_data_i  = line_of(req_addr);
            @(negedge clk);
            refill_r_valid_i = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial
   begin : stimulus
      row_t                       row;
      int                         exp_refill;
      int                         base_gnt;
      int                         base_rv;
      int                         base_ref;
      logic [`ICACHE_FETCH_W-1:0] exp_word;

      arst_n_i        = 1'b0;
      fetch_req_i     = 1'b0;
      fetch_addr_i    = '0;
      bypass_icache_i = 1'b0;
      flush_icache_i  = 1'b0;
      cur_addr        = '0;
      model_invalidate();
      for (int s = 0; s < `ICACHE_NB_SETS; s++)
         m_rr[s] = 1'b0;

      // Address, bypass, flush
      rows[0]  = '{32'h1000_0104, 1'b0, 1'b0};   // Cold miss
      rows[1]  = '{32'h1000_0104, 1'b0, 1'b0};   // Repeat hits
      rows[2]  = '{32'h1000_0100, 1'b0, 1'b0};
      rows[3]  = '{32'h1000_0108, 1'b0, 1'b0};
      rows[4]  = '{32'h1000_010C, 1'b0, 1'b0};
      rows[5]  = '{32'h0000_1030, 1'b0, 1'b0};   // Three lines in set 3
      rows[6]  = '{32'h0000_2030, 1'b0, 1'b0};
      rows[7]  = '{32'h0000_3030, 1'b0, 1'b0};
      rows[8]  = '{32'h0000_2034, 1'b0, 1'b0};
      rows[9]  = '{32'h0000_1038, 1'b0, 1'b0};
      rows[10] = '{32'h0000_303C, 1'b0, 1'b0};
      rows[11] = '{32'h1000_0104, 1'b0, 1'b1};   // Flush first
      rows[12] = '{32'h1000_0100, 1'b0, 1'b0};
      rows[13] = '{32'h0000_3030, 1'b1, 1'b0};   // Bypass
      rows[14] = '{32'h0000_3030, 1'b1, 1'b0};
      rows[15] = '{32'h1000_0108, 1'b1, 1'b0};
      rows[16] = '{32'h1000_0108, 1'b0, 1'b0};   // Back to caching
      rows[17] = '{32'h1000_0108, 1'b0, 1'b0};
      rows[18] = '{32'h0000_3030, 1'b0, 1'b0};
      rows[19] = '{32'h0000_0FF4, 1'b0, 1'b0};

      @(negedge clk);
      check(!fetch_gnt_o && !fetch_rvalid_o && !refill_req_o, "handshakes active in reset");
      check(!cache_is_bypassed_o && cache_is_flushed_o, "wrong status outputs in reset");
      @(negedge clk);
      arst_n_i = 1'b1;

      for (int r = 0; r < NB_ROWS; r++)
      begin
         row      = rows[r];
         cur_addr = row.addr;

         if (row.flush)
         begin
            flush_icache_i = 1'b1;
            @(negedge clk);
            flush_icache_i = 1'b0;
            while (!cache_is_flushed_o) @(negedge clk);
            model_invalidate();
         end

         if (row.bypass != bypass_icache_i)
         begin
            bypass_icache_i = row.bypass;
            while (cache_is_bypassed_o != row.bypass) @(negedge clk);
            if (row.bypass)
               model_invalidate();   // Entering bypass drops every line
         end
         check(cache_is_bypassed_o == row.bypass, $sformatf("row %0d bypass status", r));

         model_access(row.addr, row.bypass, exp_refill);
         exp_word = {row.addr[31:2], 2'b00} ^ 32'hA5A5_0000;

         base_gnt     = gnt_total;
         base_rv      = rv_total;
         base_ref     = ref_total;
         fetch_req_i  = 1'b1;
         fetch_addr_i = row.addr;
         while (gnt_total == base_gnt) @(negedge clk);
         fetch_req_i  = 1'b0;
         while (rv_total == base_rv) @(negedge clk);
         @(negedge clk);   // Room for a stray second rvalid

         check(rv_total - base_rv == 1, $sformatf("row %0d rvalid count %0d", r,
               rv_total - base_rv));
         check(rv_data == exp_word, $sformatf("row %0d rdata %h, expected %h", r,
               rv_data, exp_word));
         check(ref_total - base_ref == exp_refill, $sformatf("row %0d refills %0d, expected %0d",
               r, ref_total - base_ref, exp_refill));
         if (exp_refill == 0)
            check(rv_cyc == gnt_cyc + 1, $sformatf("row %0d hit rvalid %0d cycles after grant",
                  r, rv_cyc - gnt_cyc));
         else if (!row.bypass)
            check(!cache_is_flushed_o, $sformatf("row %0d flushed flag stuck after refill", r));
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* pri_icache.sv */
// Private instruction cache for one fetch port
// 2-way, 16 sets of 128-bit lines, refilled one line per beat
// Wires the config block, the controller and the two banks

`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module pri_icache
(
   input  logic                          clk,
   input  logic                          arst_n_i,

   // Processor fetch port
   input  logic                          fetch_req_i,
   input  logic [`ICACHE_ADDR_W-1:0]     fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [`ICACHE_FETCH_W-1:0]    fetch_rdata_o,

   // Refill port
   output logic                          refill_req_o,
   input  logic                          refill_gnt_i,
   output logic [`ICACHE_ADDR_W-1:0]     refill_addr_o,
   input  logic                          refill_r_valid_i,
   input  logic [`ICACHE_LINE_W-1:0]     refill_r_data_i,

   // Control and status
   input  logic                          bypass_icache_i,
   output logic                          cache_is_bypassed_o,
   input  logic                          flush_icache_i,
   output logic                          cache_is_flushed_o
);

   icache_ctrl_pkg::cfg_t        cfg;
   icache_ctrl_pkg::tag_wr_t     tag_wr;
   icache_ctrl_pkg::data_wr_t    data_wr;
   icache_addr_pkg::way_sel_t    hit_way;
   icache_addr_pkg::way_sel_t    victim_way;
   icache_addr_pkg::way_sel_t    rd_way;
   icache_addr_pkg::tag_t        lookup_tag;
   icache_addr_pkg::line_t       rd_line;
   logic [`ICACHE_SET_W-1:0]     lookup_set;
   logic [`ICACHE_SET_W-1:0]     rd_set;
   logic                         invalidate;
   logic                         busy;

   icache_cfg_regs i_icache_cfg_regs
   (
      .clk                 ( clk                 ),
      .arst_n_i            ( arst_n_i            ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .flush_icache_i      ( flush_icache_i      ),
      .busy_i              ( busy                ),
      .cfg_o               ( cfg                 ),
      .invalidate_o        ( invalidate          ),
      .cache_is_bypassed_o ( cache_is_bypassed_o )
   );

   icache_controller i_icache_controller
   (
      .clk              ( clk              ),
      .arst_n_i         ( arst_n_i         ),
      .cfg_i            ( cfg              ),
      .fetch_req_i      ( fetch_req_i      ),
      .fetch_addr_i     ( fetch_addr_i     ),
      .busy_o           ( busy             ),
      .fetch_gnt_o      ( fetch_gnt_o      ),
      .fetch_rvalid_o   ( fetch_rvalid_o   ),
      .fetch_rdata_o    ( fetch_rdata_o    ),
      .lookup_set_o     ( lookup_set       ),
      .lookup_tag_o     ( lookup_tag       ),
      .hit_way_i        ( hit_way          ),
      .victim_way_i     ( victim_way       ),
      .tag_wr_o         ( tag_wr           ),
      .data_wr_o        ( data_wr          ),
      .rd_set_o         ( rd_set           ),
      .rd_way_o         ( rd_way           ),
      .rd_line_i        ( rd_line          ),
      .refill_req_o     ( refill_req_o     ),
      .refill_gnt_i     ( refill_gnt_i     ),
      .refill_addr_o    ( refill_addr_o    ),
      .refill_r_valid_i ( refill_r_valid_i ),
      .refill_r_data_i  ( refill_r_data_i  )
   );

   icache_tag_bank i_icache_tag_bank
   (
      .clk                ( clk                ),
      .arst_n_i           ( arst_n_i           ),
      .lookup_set_i       ( lookup_set         ),
      .lookup_tag_i       ( lookup_tag         ),
      .tag_wr_i           ( tag_wr             ),
      .invalidate_i       ( invalidate         ),
      .hit_way_o          ( hit_way            ),
      .victim_way_o       ( victim_way         ),
      .cache_is_flushed_o ( cache_is_flushed_o )
   );

   icache_data_bank i_icache_data_bank
   (
      .clk       ( clk     ),
      .data_wr_i ( data_wr ),
      .rd_set_i  ( rd_set  ),
      .rd_way_i  ( rd_way  ),
      .rd_line_o ( rd_line )
   );

endmodule

`default_nettype wire

/* icache_controller.sv */
// Fetch FSM of the instruction cache
// Grants in IDLE, returns hits the next cycle, refills misses into the
// victim way and serves bypass fetches straight from the refill beat

`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_controller
(
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  icache_ctrl_pkg::cfg_t         cfg_i,

   // Processor side
   input  logic                          fetch_req_i,
   input  icache_addr_pkg::fetch_addr_t  fetch_addr_i,
   output logic                          busy_o,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [`ICACHE_FETCH_W-1:0]    fetch_rdata_o,

   // Tag bank
   output logic [`ICACHE_SET_W-1:0]      lookup_set_o,
   output icache_addr_pkg::tag_t         lookup_tag_o,
   input  icache_addr_pkg::way_sel_t     hit_way_i,
   input  icache_addr_pkg::way_sel_t     victim_way_i,
   output icache_ctrl_pkg::tag_wr_t      tag_wr_o,

   // Data bank
   output icache_ctrl_pkg::data_wr_t     data_wr_o,
   output logic [`ICACHE_SET_W-1:0]      rd_set_o,
   output icache_addr_pkg::way_sel_t     rd_way_o,
   input  icache_addr_pkg::line_t        rd_line_i,

   // Refill port
   output logic                          refill_req_o,
   input  logic                          refill_gnt_i,
   output logic [`ICACHE_ADDR_W-1:0]     refill_addr_o,
   input  logic                          refill_r_valid_i,
   input  icache_addr_pkg::line_t        refill_r_data_i
);

   icache_ctrl_pkg::ctrl_state_e   state_q, state_d;
   icache_addr_pkg::fetch_addr_t   addr_q;     // Granted fetch address
   icache_addr_pkg::way_sel_t      hit_q;      // Hit way at grant time
   logic [`ICACHE_FETCH_W-1:0]     rdata_q;    // Word taken from the beat
   logic                           beat_in;    // Refill beat for this fetch
   logic                           line_wr;    // Beat goes into the cache

   // Pick the 32-bit word addressed by bits [3:2]
   function automatic logic [`ICACHE_FETCH_W-1:0] sel_word
   (
      input icache_addr_pkg::line_t     line,
      input logic [`ICACHE_OFS_W-1:0]   ofs
   );
      return line[ofs[`ICACHE_OFS_W-1:2]*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////

   assign busy_o      = (state_q != icache_ctrl_pkg::IDLE);
   assign fetch_gnt_o = (state_q == icache_ctrl_pkg::IDLE) & fetch_req_i & ~cfg_i.hold;
   assign beat_in     = (state_q == icache_ctrl_pkg::REFILL_WAIT) & refill_r_valid_i;
   assign line_wr     = beat_in & ~cfg_i.bypass;   // Bypass writes nothing

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         icache_ctrl_pkg::IDLE:
            if (fetch_gnt_o)
            begin
               if (cfg_i.bypass || hit_way_i == '0)
                  state_d = icache_ctrl_pkg::REFILL_REQ;
               else
                  state_d = icache_ctrl_pkg::HIT_RET;
            end
         icache_ctrl_pkg::HIT_RET:     state_d = icache_ctrl_pkg::IDLE;
         icache_ctrl_pkg::REFILL_REQ:
            if (refill_gnt_i)
               state_d = icache_ctrl_pkg::REFILL_WAIT;
         icache_ctrl_pkg::REFILL_WAIT:
            if (refill_r_valid_i)
               state_d = icache_ctrl_pkg::RESP;
         icache_ctrl_pkg::RESP:        state_d = icache_ctrl_pkg::IDLE;
         default:                      state_d = icache_ctrl_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_q <= icache_ctrl_pkg::IDLE;
      else
         state_q <= state_d;
   end

   // Fetch context, meaningful only while busy
   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
      begin
         addr_q <= fetch_addr_i;
         hit_q  <= hit_way_i;
      end
      if (beat_in)
         rdata_q <= sel_word(refill_r_data_i, addr_q.ofs);
   end

   //////////////////////////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////////////////////////

   // Live address in IDLE, held address for the victim choice later on
   assign lookup_set_o = busy_o ? addr_q.set : fetch_addr_i.set;
   assign lookup_tag_o = busy_o ? addr_q.tag : fetch_addr_i.tag;

   assign rd_set_o = addr_q.set;
   assign rd_way_o = hit_q;

   assign fetch_rvalid_o = (state_q == icache_ctrl_pkg::HIT_RET) |
                           (state_q == icache_ctrl_pkg::RESP);
   assign fetch_rdata_o  = (state_q == icache_ctrl_pkg::HIT_RET) ?
                           sel_word(rd_line_i, addr_q.ofs) : rdata_q;

   assign refill_req_o  = (state_q == icache_ctrl_pkg::REFILL_REQ);
   assign refill_addr_o = {addr_q.tag, addr_q.set, {`ICACHE_OFS_W{1'b0}}};  // Line aligned

   assign tag_wr_o.en  = line_wr;
   assign tag_wr_o.way = victim_way_i;
   assign tag_wr_o.set = addr_q.set;
   assign tag_wr_o.tag = addr_q.tag;

   assign data_wr_o.en   = line_wr;
   assign data_wr_o.way  = victim_way_i;
   assign data_wr_o.set  = addr_q.set;
   assign data_wr_o.line = refill_r_data_i;

endmodule

`default_nettype wire

/* icache_data_bank.sv */
// Line storage for all ways as a flip-flop array
// One full line is written per refill, the read is combinational

`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_data_bank
(
   input  logic                       clk,

   input  icache_ctrl_pkg::data_wr_t  data_wr_i,
   input  logic [`ICACHE_SET_W-1:0]   rd_set_i,
   input  icache_addr_pkg::way_sel_t  rd_way_i,   // One-hot

   output icache_addr_pkg::line_t     rd_line_o
);

   icache_addr_pkg::line_t line_q [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (data_wr_i.en && data_wr_i.way[w])
            line_q[w][data_wr_i.set] <= data_wr_i.line;
      end
   end

   // AND-OR mux over the ways, zero if no way selected
   always_comb
   begin
      rd_line_o = '0;
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (rd_way_i[w])
            rd_line_o = rd_line_o | line_q[w][rd_set_i];
      end
   end

endmodule

`default_nettype wire

/* icache_tag_bank.sv */
// Tag and valid storage for all ways, plus a round-robin bit per set
// Lookup and victim choice are combinational on the lookup set
// Writes and invalidate-all land at the next edge, invalidate wins

`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_tag_bank
(
   input  logic                       clk,
   input  logic                       arst_n_i,

   input  logic [`ICACHE_SET_W-1:0]   lookup_set_i,
   input  icache_addr_pkg::tag_t      lookup_tag_i,
   input  icache_ctrl_pkg::tag_wr_t   tag_wr_i,
   input  logic                       invalidate_i,

   output icache_addr_pkg::way_sel_t  hit_way_o,
   output icache_addr_pkg::way_sel_t  victim_way_o,
   output logic                       cache_is_flushed_o
);

   localparam int RR_W = $clog2(`ICACHE_NB_WAYS);

   icache_addr_pkg::tag_t        tag_q   [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];
   logic [`ICACHE_NB_WAYS-1:0]   valid_q [`ICACHE_NB_SETS];  // Way vector per set
   logic [RR_W-1:0]              rr_q    [`ICACHE_NB_SETS];  // Next way to replace
   logic                         flushed_q;

   //////////////////////////////////////////////////////////////////////
   // Lookup
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
         hit_way_o[w] = valid_q[lookup_set_i][w] && (tag_q[w][lookup_set_i] == lookup_tag_i);
   end

   // Round-robin way unless one is free, lowest free way wins
   always_comb
   begin
      victim_way_o = icache_addr_pkg::way_sel_t'(1) << rr_q[lookup_set_i];
      for (int w = `ICACHE_NB_WAYS-1; w >= 0; w--)
      begin
         if (!valid_q[lookup_set_i][w])
            victim_way_o = icache_addr_pkg::way_sel_t'(1) << w;
      end
   end

   assign cache_is_flushed_o = flushed_q;

   //////////////////////////////////////////////////////////////////////
   // Update
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int s = 0; s < `ICACHE_NB_SETS; s++)
         begin
            valid_q[s] <= '0;
            rr_q[s]    <= '0;
         end
         flushed_q <= 1'b1;   // Nothing valid out of reset
      end
      else if (invalidate_i)
      begin
         for (int s = 0; s < `ICACHE_NB_SETS; s++)
            valid_q[s] <= '0;
         flushed_q <= 1'b1;
      end
      else if (tag_wr_i.en)
      begin
         valid_q[tag_wr_i.set] <= valid_q[tag_wr_i.set] | tag_wr_i.way;
         rr_q[tag_wr_i.set]    <= rr_q[tag_wr_i.set] + 1'b1;  // Toggle for 2 ways
         flushed_q             <= 1'b0;
      end
   end

   // Tag values themselves, qualified by the valid bits
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (tag_wr_i.en && tag_wr_i.way[w])
            tag_q[w][tag_wr_i.set] <= tag_wr_i.tag;
      end
   end

endmodule

`default_nettype wire

/* icache_cfg_regs.sv */
// Bypass and flush configuration block, sits beside the controller
// Latches flush pulses and bypass changes, holds off new fetches and
// applies the change only while the controller is idle

`timescale 1ns/1ps
`default_nettype none

module icache_cfg_regs
(
   input  logic                   clk,
   input  logic                   arst_n_i,

   input  logic                   bypass_icache_i,   // Level
   input  logic                   flush_icache_i,    // Pulse
   input  logic                   busy_i,            // Controller not in IDLE

   output icache_ctrl_pkg::cfg_t  cfg_o,
   output logic                   invalidate_o,      // Invalidate all tags
   output logic                   cache_is_bypassed_o
);

   logic bypass_q;       // Applied bypass level
   logic flush_pend_q;   // Flush seen but not yet applied
   logic bypass_chg;     // Requested level differs from applied one
   logic apply_chg;      // Change goes out this cycle

   assign bypass_chg = bypass_icache_i ^ bypass_q;

   // Only between fetches, busy comes from registered state
   assign apply_chg = (flush_pend_q | bypass_chg) & ~busy_i;

   // Flush, or entering bypass, drops every line
   assign invalidate_o = apply_chg & (flush_pend_q | (bypass_chg & bypass_icache_i));

   // Raised as soon as anything is pending, drops after apply
   assign cfg_o.hold   = flush_icache_i | flush_pend_q | bypass_chg;
   assign cfg_o.bypass = bypass_q;

   assign cache_is_bypassed_o = bypass_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         bypass_q     <= 1'b0;
         flush_pend_q <= 1'b0;
      end
      else
      begin
         if (apply_chg)
            bypass_q <= bypass_icache_i;
         // A new pulse in the apply cycle stays pending
         flush_pend_q <= flush_icache_i | (flush_pend_q & ~apply_chg);
      end
   end

endmodule

`default_nettype wire

/* icache_ctrl_pkg.sv */
// Controller states and the control structs passed between cache blocks
// The structs travel from the controller and the config block to the banks

`default_nettype none

`include "icache_defs.svh"

package icache_ctrl_pkg;

   typedef enum logic [2:0] {
      IDLE,         // Waiting for a fetch, lookup is live
      HIT_RET,      // Return the hit word
      REFILL_REQ,   // Hold refill request until grant
      REFILL_WAIT,  // Wait for the refill beat
      RESP          // Return the word taken from the beat
   } ctrl_state_e;

   typedef struct packed {
      logic bypass;  // Applied bypass level
      logic hold;    // Do not grant a new fetch
   } cfg_t;

   typedef struct packed {
      logic                           en;
      icache_addr_pkg::way_sel_t      way;
      logic [`ICACHE_SET_W-1:0]       set;
      icache_addr_pkg::tag_t          tag;
   } tag_wr_t;

   typedef struct packed {
      logic                           en;
      icache_addr_pkg::way_sel_t      way;
      logic [`ICACHE_SET_W-1:0]       set;
      icache_addr_pkg::line_t         line;
   } data_wr_t;

endpackage

`default_nettype wire

/* icache_addr_pkg.sv */
// Address and storage types for the private instruction cache
// Used by the controller, the banks and the top level

`default_nettype none

`include "icache_defs.svh"

package icache_addr_pkg;

   typedef logic [`ICACHE_TAG_W-1:0]   tag_t;     // Full tag, no reduced form
   typedef logic [`ICACHE_LINE_W-1:0]  line_t;    // One cache line or refill beat
   typedef logic [`ICACHE_NB_WAYS-1:0] way_sel_t; // One-hot way select

   // Fetch address split into its cache fields
   typedef struct packed {
      tag_t                      tag;
      logic [`ICACHE_SET_W-1:0]  set;
      logic [`ICACHE_OFS_W-1:0]  ofs;   // Bits [3:2] pick the word
   } fetch_addr_t;

endpackage

`default_nettype wire

/* icache_defs.svh */
// Geometry and width macros for the private instruction cache
// Include this file wherever a width or a cache dimension is needed
// 2 ways, 16 sets, 128-bit lines holding four 32-bit fetch words

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define ICACHE_ADDR_W   32   // Fetch and refill address
`define ICACHE_FETCH_W  32   // One fetch word
`define ICACHE_LINE_W   128  // Refill beat, equal to one line

//////////////////////////////////////////////////////////////////////
// Geometry
//////////////////////////////////////////////////////////////////////

`define ICACHE_NB_WAYS  2
`define ICACHE_NB_SETS  16

// Address split, tag + set + offset must equal ICACHE_ADDR_W
`define ICACHE_OFS_W    4    // Byte offset inside a line
`define ICACHE_SET_W    4    // log2 of ICACHE_NB_SETS
`define ICACHE_TAG_W    24   // Remaining upper address bits

`endif
